// File: design/sdram_sched_pkg.sv
`default_nettype none

package sdram_sched_pkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int BA_W   = 2;
  localparam int ROW_W  = 13;
  localparam int COL_W  = 10;
  localparam int ADDR_W = 13;
  localparam int DQ_W   = 16;
  localparam int BANKS  = 1 << BA_W;

  // Address bit that turns a PRE into PRE-all
  localparam int PRE_ALL_BIT = 10;

  typedef logic [BA_W-1:0]   ba_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DQ_W-1:0]   dq_t;

  ////////////////////
  // Commands
  ////////////////////
  // Encoded as {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    CMD_NOP = 4'b0111,
    CMD_ACT = 4'b0011,
    CMD_RD  = 4'b0101,
    CMD_WR  = 4'b0100,
    CMD_PRE = 4'b0010,
    CMD_REF = 4'b0001
  } sdram_cmd_e;

endpackage

`default_nettype wire

// File: design/sdram_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sdram_cmd_if;

  // Request side, held stable while req is high
  logic                        req;
  sdram_sched_pkg::sdram_cmd_e cmd;
  sdram_sched_pkg::ba_t        ba;
  sdram_sched_pkg::addr_t      addr;

  // Single-cycle pulse from the arbiter
  logic                        grant;

  modport requester (
    output req, cmd, ba, addr,
    input  grant
  );

  modport arbiter (
    input  req, cmd, ba, addr,
    output grant
  );

endinterface

`default_nettype wire

// File: design/sdram_bank_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_bank_timer #(
  parameter int T_RCD = 3,
  parameter int T_RP  = 3,
  parameter int T_RAS = 6,
  parameter int T_WR  = 2
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire sdram_sched_pkg::sdram_cmd_e cmd_i,
  input  wire sdram_sched_pkg::ba_t        ba_i,
  input  wire sdram_sched_pkg::addr_t      addr_i,
  output logic [sdram_sched_pkg::BANKS-1:0] bank_open_o,
  output sdram_sched_pkg::row_t             bank_row_o [sdram_sched_pkg::BANKS],
  output logic [sdram_sched_pkg::BANKS-1:0] act_ok_o,
  output logic [sdram_sched_pkg::BANKS-1:0] rw_ok_o,
  output logic [sdram_sched_pkg::BANKS-1:0] pre_ok_o
);

  localparam int BANKS = sdram_sched_pkg::BANKS;
  localparam int CW    = 8;

  // Counter slots per bank
  localparam int K_RCD = 0;
  localparam int K_RP  = 1;
  localparam int K_RAS = 2;
  localparam int K_WR  = 3;

  // Two cycles are already spent between grant and status update
  localparam logic [CW-1:0] LD [4] = '{
    CW'((T_RCD > 2) ? T_RCD - 2 : 0),
    CW'((T_RP  > 2) ? T_RP  - 2 : 0),
    CW'((T_RAS > 2) ? T_RAS - 2 : 0),
    CW'((T_WR  > 2) ? T_WR  - 2 : 0)
  };

  logic [CW-1:0] cnt  [BANKS][4];
  logic [3:0]    load [BANKS];

  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      load[b] = 4'b0000;
      if (ba_i == sdram_sched_pkg::ba_t'(b) || cmd_i == sdram_sched_pkg::CMD_PRE)
      begin
        unique case (cmd_i)
          sdram_sched_pkg::CMD_ACT:
          begin
            load[b][K_RCD] = 1'b1;
            load[b][K_RAS] = 1'b1;
          end
          sdram_sched_pkg::CMD_PRE:
            load[b][K_RP] = addr_i[sdram_sched_pkg::PRE_ALL_BIT] ||
                            ba_i == sdram_sched_pkg::ba_t'(b);
          sdram_sched_pkg::CMD_WR:
            load[b][K_WR] = 1'b1;
          default:
            load[b] = 4'b0000;
        endcase
      end
    end
  end

  ////////////////////
  // Down-counters
  ////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int b = 0; b < BANKS; b++)
        for (int k = 0; k < 4; k++)
          cnt[b][k] <= '0;
    end
    else
    begin
      for (int b = 0; b < BANKS; b++)
        for (int k = 0; k < 4; k++)
          if (load[b][k])
            cnt[b][k] <= LD[k];
          else if (cnt[b][k] != '0)
            cnt[b][k] <= cnt[b][k] - 1'b1;
    end
  end

  // Open flags
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bank_open_o <= '0;
    else
      for (int b = 0; b < BANKS; b++)
        if (load[b][K_RAS])
          bank_open_o[b] <= 1'b1;
        else if (load[b][K_RP])
          bank_open_o[b] <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    for (int b = 0; b < BANKS; b++)
      if (load[b][K_RAS])
        bank_row_o[b] <= sdram_sched_pkg::row_t'(addr_i);
  end

  always_comb
  begin
    for (int b = 0; b < BANKS; b++)
    begin
      act_ok_o[b] = cnt[b][K_RP] == '0;
      rw_ok_o[b]  = cnt[b][K_RCD] == '0;
      pre_ok_o[b] = cnt[b][K_RAS] == '0 && cnt[b][K_WR] == '0;
    end
  end

  // Column access needs an open row
  a_rw_open: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd_i == sdram_sched_pkg::CMD_RD || cmd_i == sdram_sched_pkg::CMD_WR)
      |-> bank_open_o[ba_i]);

endmodule

`default_nettype wire

// File: design/sdram_port_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_engine (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   rdreq_i,
  input  wire sdram_sched_pkg::ba_t   rdba_i,
  input  wire sdram_sched_pkg::row_t  rdrow_i,
  input  wire sdram_sched_pkg::col_t  rdcol_i,
  input  wire logic                   wrreq_i,
  input  wire sdram_sched_pkg::ba_t   wrba_i,
  input  wire sdram_sched_pkg::row_t  wrrow_i,
  input  wire sdram_sched_pkg::col_t  wrcol_i,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] bank_open_i,
  input  wire sdram_sched_pkg::row_t  bank_row_i [sdram_sched_pkg::BANKS],
  input  wire logic [sdram_sched_pkg::BANKS-1:0] act_ok_i,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] rw_ok_i,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] pre_ok_i,
  output logic                        rdrdy_o,
  output logic                        wrrdy_o,
  sdram_cmd_if.requester              bus
);

  typedef enum logic {
    PE_IDLE,
    PE_BUSY
  } pe_state_e;

  pe_state_e             state;
  sdram_sched_pkg::ba_t  ba;
  sdram_sched_pkg::row_t row;
  sdram_sched_pkg::col_t col;
  logic                  hit;

  // Reads win over writes
  assign ba  = rdreq_i ? rdba_i  : wrba_i;
  assign row = rdreq_i ? rdrow_i : wrrow_i;
  assign col = rdreq_i ? rdcol_i : wrcol_i;
  assign hit = bank_open_i[ba] && bank_row_i[ba] == row;

  ////////////////////
  // Next command
  ////////////////////
  always_comb
  begin
    bus.req  = 1'b0;
    bus.cmd  = sdram_sched_pkg::CMD_NOP;
    bus.ba   = ba;
    bus.addr = '0;
    if (state == PE_IDLE && (rdreq_i || wrreq_i))
    begin
      if (hit)
      begin
        bus.req  = rw_ok_i[ba];
        bus.cmd  = rdreq_i ? sdram_sched_pkg::CMD_RD : sdram_sched_pkg::CMD_WR;
        bus.addr = sdram_sched_pkg::addr_t'(col);
      end
      else if (bank_open_i[ba])
      begin
        // Row conflict, close the bank first
        bus.req = pre_ok_i[ba];
        bus.cmd = sdram_sched_pkg::CMD_PRE;
      end
      else
      begin
        bus.req  = act_ok_i[ba];
        bus.cmd  = sdram_sched_pkg::CMD_ACT;
        bus.addr = sdram_sched_pkg::addr_t'(row);
      end
    end
  end

  // Hold off one cycle after any grant, bank status is still stale
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state   <= PE_IDLE;
      rdrdy_o <= 1'b0;
      wrrdy_o <= 1'b0;
    end
    else
    begin
      state   <= bus.grant ? PE_BUSY : PE_IDLE;
      rdrdy_o <= bus.grant && bus.cmd == sdram_sched_pkg::CMD_RD;
      wrrdy_o <= bus.grant && bus.cmd == sdram_sched_pkg::CMD_WR;
    end
  end

endmodule

`default_nettype wire

// File: design/sdram_refresh_engine.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_refresh_engine #(
  parameter int REF_INTERVAL = 200
) (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] bank_open_i,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] act_ok_i,
  input  wire logic [sdram_sched_pkg::BANKS-1:0] pre_ok_i,
  sdram_cmd_if.requester                         bus
);

  localparam int IW = $clog2(REF_INTERVAL + 1);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_PRECH,
    RF_REF
  } rf_state_e;

  rf_state_e     state;
  logic [IW-1:0] interval_cnt;
  logic          tick;
  logic [2:0]    pending;
  logic          ref_done;

  assign tick     = interval_cnt == IW'(REF_INTERVAL - 1);
  assign ref_done = bus.grant && state == RF_REF;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      interval_cnt <= '0;
      pending      <= '0;
      state        <= RF_IDLE;
    end
    else
    begin
      interval_cnt <= tick ? '0 : interval_cnt + 1'b1;
      if (tick && !ref_done && pending != 3'd7)
        pending <= pending + 1'b1;
      else if (!tick && ref_done)
        pending <= pending - 1'b1;

      unique case (state)
        RF_IDLE:  if (pending != '0) state <= (|bank_open_i) ? RF_PRECH : RF_REF;
        RF_PRECH: if (bus.grant || bank_open_i == '0) state <= RF_REF;
        RF_REF:
          if (ref_done)          state <= RF_IDLE;
          else if (|bank_open_i) state <= RF_PRECH;
        default:                 state <= RF_IDLE;
      endcase
    end
  end

  ////////////////////
  // Request
  ////////////////////
  always_comb
  begin
    bus.ba   = '0;
    bus.addr = '0;
    bus.addr[sdram_sched_pkg::PRE_ALL_BIT] = state == RF_PRECH;
    bus.cmd  = (state == RF_PRECH) ? sdram_sched_pkg::CMD_PRE : sdram_sched_pkg::CMD_REF;
    unique case (state)
      RF_PRECH: bus.req = |bank_open_i && &(pre_ok_i | ~bank_open_i);
      RF_REF:   bus.req = bank_open_i == '0 && &act_ok_i;
      default:  bus.req = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/sdram_cmd_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_arbiter #(
  parameter int PORTS = 2,
  parameter int T_RC  = 9,
  localparam int PW   = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire sdram_sched_pkg::dq_t  wrd_i [PORTS],
  output sdram_sched_pkg::sdram_cmd_e cmd_o,
  output sdram_sched_pkg::ba_t       ba_o,
  output sdram_sched_pkg::addr_t     addr_o,
  output sdram_sched_pkg::dq_t       dq_o,
  output logic                       dqoe_o,
  output logic [PW-1:0]              port_o,
  sdram_cmd_if.arbiter               req_if [PORTS+1]
);

  localparam int N  = PORTS + 1;
  localparam int CW = 8;

  logic [N-1:0]                req;
  logic [N-1:0]                eligible;
  logic [N-1:0]                grant;
  sdram_sched_pkg::sdram_cmd_e cmd  [N];
  sdram_sched_pkg::ba_t        ba   [N];
  sdram_sched_pkg::addr_t      addr [N];

  sdram_sched_pkg::sdram_cmd_e cmd_nxt;
  sdram_sched_pkg::ba_t        ba_nxt;
  sdram_sched_pkg::addr_t      addr_nxt;
  sdram_sched_pkg::dq_t        dq_nxt;
  logic [PW-1:0]               port_nxt;
  logic [CW-1:0]               trc_cnt;
  logic                        trc_ok;

  assign trc_ok = trc_cnt == '0;

  for (genvar i = 0; i < N; i++)
  begin : gen_req
    assign req[i]          = req_if[i].req;
    assign cmd[i]          = req_if[i].cmd;
    assign ba[i]           = req_if[i].ba;
    assign addr[i]         = req_if[i].addr;
    assign req_if[i].grant = grant[i];

    // No grant right after an issue, requesters still see old bank status
    assign eligible[i] = req[i] && cmd_o == sdram_sched_pkg::CMD_NOP &&
                         (trc_ok || !(cmd[i] == sdram_sched_pkg::CMD_ACT ||
                                      cmd[i] == sdram_sched_pkg::CMD_REF));
  end

  ////////////////////
  // Fixed priority
  ////////////////////
  always_comb
  begin
    grant = '0;
    if (eligible[PORTS])
      grant[PORTS] = 1'b1;
    else
      for (int i = PORTS - 1; i >= 0; i--)
        if (eligible[i])
          grant = N'(1) << i;

    cmd_nxt  = sdram_sched_pkg::CMD_NOP;
    ba_nxt   = '0;
    addr_nxt = '0;
    dq_nxt   = '0;
    port_nxt = '0;
    for (int i = 0; i < N; i++)
      if (grant[i])
      begin
        cmd_nxt  = cmd[i];
        ba_nxt   = ba[i];
        addr_nxt = addr[i];
      end
    for (int i = 0; i < PORTS; i++)
      if (grant[i])
      begin
        dq_nxt   = wrd_i[i];
        port_nxt = PW'(i);
      end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cmd_o   <= sdram_sched_pkg::CMD_NOP;
      dqoe_o  <= 1'b0;
      trc_cnt <= '0;
    end
    else
    begin
      cmd_o  <= cmd_nxt;
      dqoe_o <= cmd_nxt == sdram_sched_pkg::CMD_WR;
      if (cmd_nxt == sdram_sched_pkg::CMD_ACT || cmd_nxt == sdram_sched_pkg::CMD_REF)
        trc_cnt <= CW'((T_RC > 1) ? T_RC - 1 : 0);
      else if (!trc_ok)
        trc_cnt <= trc_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ba_o   <= ba_nxt;
    addr_o <= addr_nxt;
    dq_o   <= dq_nxt;
    port_o <= port_nxt;
  end

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(grant));
  a_grant_req: assert property (@(posedge clk_i) disable iff (!rst_ni) (grant & ~req) == '0);

endmodule

`default_nettype wire

// File: design/sdram_read_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_read_tracker #(
  parameter int PORTS = 2,
  parameter int CL    = 3,
  localparam int PW   = (PORTS > 1) ? $clog2(PORTS) : 1
) (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire sdram_sched_pkg::sdram_cmd_e cmd_i,
  input  wire logic [PW-1:0]               grant_port_i,
  output logic [PORTS-1:0]                 rdqvalid_o
);

  // Stage k holds a read issued k+1 cycles ago
  logic [CL-1:0] valid;
  logic [PW-1:0] port [CL];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      valid <= '0;
    else
      valid <= {valid[CL-2:0], cmd_i == sdram_sched_pkg::CMD_RD};
  end

  always_ff @(posedge clk_i)
  begin
    port[0] <= grant_port_i;
    for (int k = 1; k < CL; k++)
      port[k] <= port[k-1];
  end

  assign rdqvalid_o = valid[CL-1] ? (PORTS'(1) << port[CL-1]) : '0;

  a_one_valid: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rdqvalid_o));

endmodule

`default_nettype wire

// File: design/sdram_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_top #(
  parameter int PORTS        = 2,
  parameter int CL           = 3,
  parameter int T_RCD        = 3,
  parameter int T_RP         = 3,
  parameter int T_RAS        = 6,
  parameter int T_WR         = 2,
  parameter int T_RC         = 9,
  parameter int REF_INTERVAL = 200
) (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire logic                   rdreq_i    [PORTS],
  input  wire sdram_sched_pkg::ba_t   rdba_i     [PORTS],
  input  wire sdram_sched_pkg::row_t  rdrow_i    [PORTS],
  input  wire sdram_sched_pkg::col_t  rdcol_i    [PORTS],
  output logic                        rdrdy_o    [PORTS],
  input  wire logic                   wrreq_i    [PORTS],
  input  wire sdram_sched_pkg::ba_t   wrba_i     [PORTS],
  input  wire sdram_sched_pkg::row_t  wrrow_i    [PORTS],
  input  wire sdram_sched_pkg::col_t  wrcol_i    [PORTS],
  input  wire sdram_sched_pkg::dq_t   wrd_i      [PORTS],
  output logic                        wrrdy_o    [PORTS],
  output sdram_sched_pkg::dq_t        rdq_o      [PORTS],
  output logic                        rdqvalid_o [PORTS],
  output sdram_sched_pkg::sdram_cmd_e sdram_cmd_o,
  output sdram_sched_pkg::ba_t        sdram_ba_o,
  output sdram_sched_pkg::addr_t      sdram_addr_o,
  input  wire sdram_sched_pkg::dq_t   sdram_dq_i,
  output sdram_sched_pkg::dq_t        sdram_dq_o,
  output logic                        sdram_dqoe_o
);

  localparam int BANKS = sdram_sched_pkg::BANKS;
  localparam int PW    = (PORTS > 1) ? $clog2(PORTS) : 1;

  logic [BANKS-1:0]      bank_open, act_ok, rw_ok, pre_ok;
  sdram_sched_pkg::row_t bank_row [BANKS];
  logic [PW-1:0]         issued_port;
  logic [PORTS-1:0]      rdqvalid;

  // Ports first, refresh engine in the last slot
  sdram_cmd_if req_if [PORTS+1] ();

  sdram_bank_timer #(
    .T_RCD (T_RCD),
    .T_RP  (T_RP),
    .T_RAS (T_RAS),
    .T_WR  (T_WR)
  ) u_bank_timer (
    .clk_i, .rst_ni,
    .cmd_i       (sdram_cmd_o),
    .ba_i        (sdram_ba_o),
    .addr_i      (sdram_addr_o),
    .bank_open_o (bank_open),
    .bank_row_o  (bank_row),
    .act_ok_o    (act_ok),
    .rw_ok_o     (rw_ok),
    .pre_ok_o    (pre_ok)
  );

  for (genvar p = 0; p < PORTS; p++)
  begin : gen_port
    sdram_port_engine u_port_engine (
      .clk_i, .rst_ni,
      .rdreq_i     (rdreq_i[p]),
      .rdba_i      (rdba_i[p]),
      .rdrow_i     (rdrow_i[p]),
      .rdcol_i     (rdcol_i[p]),
      .wrreq_i     (wrreq_i[p]),
      .wrba_i      (wrba_i[p]),
      .wrrow_i     (wrrow_i[p]),
      .wrcol_i     (wrcol_i[p]),
      .bank_open_i (bank_open),
      .bank_row_i  (bank_row),
      .act_ok_i    (act_ok),
      .rw_ok_i     (rw_ok),
      .pre_ok_i    (pre_ok),
      .rdrdy_o     (rdrdy_o[p]),
      .wrrdy_o     (wrrdy_o[p]),
      .bus         (req_if[p])
    );

    // All ports see the read bus, rdqvalid selects the owner
    assign rdq_o[p]      = sdram_dq_i;
    assign rdqvalid_o[p] = rdqvalid[p];
  end

  sdram_refresh_engine #(
    .REF_INTERVAL (REF_INTERVAL)
  ) u_refresh_engine (
    .clk_i, .rst_ni,
    .bank_open_i (bank_open),
    .act_ok_i    (act_ok),
    .pre_ok_i    (pre_ok),
    .bus         (req_if[PORTS])
  );

  sdram_cmd_arbiter #(
    .PORTS (PORTS),
    .T_RC  (T_RC)
  ) u_cmd_arbiter (
    .clk_i, .rst_ni,
    .wrd_i  (wrd_i),
    .cmd_o  (sdram_cmd_o),
    .ba_o   (sdram_ba_o),
    .addr_o (sdram_addr_o),
    .dq_o   (sdram_dq_o),
    .dqoe_o (sdram_dqoe_o),
    .port_o (issued_port),
    .req_if (req_if)
  );

  sdram_read_tracker #(
    .PORTS (PORTS),
    .CL    (CL)
  ) u_read_tracker (
    .clk_i, .rst_ni,
    .cmd_i        (sdram_cmd_o),
    .grant_port_i (issued_port),
    .rdqvalid_o   (rdqvalid)
  );

endmodule

`default_nettype wire

// File: verification/sdram_sched_model.svh
`ifndef SDRAM_SCHED_MODEL_SVH
`define SDRAM_SCHED_MODEL_SVH

////////////////////
// SDRAM model state
////////////////////
typedef logic [sdram_sched_pkg::BA_W+sdram_sched_pkg::ROW_W+sdram_sched_pkg::COL_W-1:0] key_t;

logic                  bank_is_open [BANKS];
sdram_sched_pkg::row_t open_row     [BANKS];
int                    last_act     [BANKS];
int                    last_pre     [BANKS];
int                    last_wr      [BANKS];
int                    last_rc;
int                    ref_count;
sdram_sched_pkg::dq_t  mem [key_t];

// Slot k holds what the read bus carries k cycles from now
logic                  pipe_v    [CL+1];
int                    pipe_port [CL+1];
sdram_sched_pkg::dq_t  pipe_data [CL+1];

// Contents of a location that was never written
function automatic sdram_sched_pkg::dq_t fill_word(input key_t key);
  return sdram_sched_pkg::dq_t'(key[15:0] ^ {key[24:16], 7'h00} ^ 16'hc3a5);
endfunction

task automatic reset_model();
  for (int b = 0; b < BANKS; b++)
  begin
    bank_is_open[b] = 1'b0;
    open_row[b]     = '0;
    last_act[b]     = -1000;
    last_pre[b]     = -1000;
    last_wr[b]      = -1000;
  end
  for (int k = 0; k <= CL; k++)
    pipe_v[k] = 1'b0;
  last_rc   = -1000;
  ref_count = 0;
  mem.delete();
endtask

// Bank rules and gaps for the command on the bus this cycle
task automatic track_command(input int rd_port);
  sdram_sched_pkg::ba_t b;
  key_t                 key;
  logic                 all;
  b   = bus_ba;
  all = bus_addr[sdram_sched_pkg::PRE_ALL_BIT];
  case (bus_cmd)
    sdram_sched_pkg::CMD_NOP: ;
    sdram_sched_pkg::CMD_ACT:
    begin
      if (bank_is_open[b])
        fail_run($sformatf("ACT to bank %0d while it is open, cycle %0d", b, cyc));
      if (cyc - last_pre[b] < T_RP)
        fail_run($sformatf("ACT to bank %0d breaks tRP, cycle %0d", b, cyc));
      if (cyc - last_rc < T_RC)
        fail_run($sformatf("ACT to bank %0d breaks tRC, cycle %0d", b, cyc));
      bank_is_open[b] = 1'b1;
      open_row[b]     = sdram_sched_pkg::row_t'(bus_addr);
      last_act[b]     = cyc;
      last_rc         = cyc;
    end
    sdram_sched_pkg::CMD_RD, sdram_sched_pkg::CMD_WR:
    begin
      if (!bank_is_open[b])
        fail_run($sformatf("Column access to closed bank %0d, cycle %0d", b, cyc));
      if (cyc - last_act[b] < T_RCD)
        fail_run($sformatf("Column access to bank %0d breaks tRCD, cycle %0d", b, cyc));
      key = {b, open_row[b], sdram_sched_pkg::col_t'(bus_addr)};
      if (bus_cmd == sdram_sched_pkg::CMD_WR)
      begin
        mem[key]  = bus_dq_out;
        last_wr[b] = cyc;
      end
      else
      begin
        pipe_v[CL]    = 1'b1;
        pipe_port[CL] = rd_port;
        pipe_data[CL] = mem.exists(key) ? mem[key] : fill_word(key);
      end
    end
    sdram_sched_pkg::CMD_PRE:
      for (int i = 0; i < BANKS; i++)
        if (all || sdram_sched_pkg::ba_t'(i) == b)
        begin
          if (!bank_is_open[i] && !all)
            fail_run($sformatf("PRE to closed bank %0d, cycle %0d", i, cyc));
          if (bank_is_open[i] && cyc - last_act[i] < T_RAS)
            fail_run($sformatf("PRE to bank %0d breaks tRAS, cycle %0d", i, cyc));
          if (bank_is_open[i] && cyc - last_wr[i] < T_WR)
            fail_run($sformatf("PRE to bank %0d breaks tWR, cycle %0d", i, cyc));
          bank_is_open[i] = 1'b0;
          last_pre[i]     = cyc;
        end
    sdram_sched_pkg::CMD_REF:
    begin
      for (int i = 0; i < BANKS; i++)
        if (bank_is_open[i] || cyc - last_pre[i] < T_RP)
          fail_run($sformatf("REF while bank %0d is open or in tRP, cycle %0d", i, cyc));
      if (cyc - last_rc < T_RC)
        fail_run($sformatf("REF breaks tRC, cycle %0d", cyc));
      last_rc   = cyc;
      ref_count = ref_count + 1;
    end
    default:
      fail_run($sformatf("Unknown command 0x%h on the bus, cycle %0d", bus_cmd, cyc));
  endcase
endtask

`endif

// File: verification/sdram_sched_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_sched_tb;

  localparam int PORTS        = 2;
  localparam int CL           = 3;
  localparam int T_RCD        = 3;
  localparam int T_RP         = 3;
  localparam int T_RAS        = 6;
  localparam int T_WR         = 2;
  localparam int T_RC         = 9;
  localparam int REF_INTERVAL = 200;
  localparam int BANKS        = sdram_sched_pkg::BANKS;
  localparam int NUM_TXN      = 400;
  localparam int TIMEOUT      = NUM_TXN * 60 + 4 * REF_INTERVAL;

  logic clk;
  logic rst_n;

  logic                        rdreq    [PORTS];
  sdram_sched_pkg::ba_t        rdba     [PORTS];
  sdram_sched_pkg::row_t       rdrow    [PORTS];
  sdram_sched_pkg::col_t       rdcol    [PORTS];
  logic                        rdrdy    [PORTS];
  logic                        wrreq    [PORTS];
  sdram_sched_pkg::ba_t        wrba     [PORTS];
  sdram_sched_pkg::row_t       wrrow    [PORTS];
  sdram_sched_pkg::col_t       wrcol    [PORTS];
  sdram_sched_pkg::dq_t        wrd      [PORTS];
  logic                        wrrdy    [PORTS];
  sdram_sched_pkg::dq_t        rdq      [PORTS];
  logic                        rdqvalid [PORTS];
  sdram_sched_pkg::sdram_cmd_e bus_cmd;
  sdram_sched_pkg::ba_t        bus_ba;
  sdram_sched_pkg::addr_t      bus_addr;
  sdram_sched_pkg::dq_t        bus_dq_in;
  sdram_sched_pkg::dq_t        bus_dq_out;
  logic                        bus_dqoe;

  // Stimulus state per port
  logic [31:0]           rng_state;
  int                    cyc;
  int                    issued;
  int                    completed;
  int                    drain;
  logic                  pend     [PORTS];
  logic                  pend_rd  [PORTS];
  sdram_sched_pkg::ba_t  req_ba   [PORTS];
  sdram_sched_pkg::row_t req_row  [PORTS];
  sdram_sched_pkg::col_t req_col  [PORTS];
  sdram_sched_pkg::dq_t  req_data [PORTS];
  int                    gap      [PORTS];

`include "sdram_sched_model.svh"

  sdram_sched_top #(
    .PORTS        (PORTS),
    .CL           (CL),
    .T_RCD        (T_RCD),
    .T_RP         (T_RP),
    .T_RAS        (T_RAS),
    .T_WR         (T_WR),
    .T_RC         (T_RC),
    .REF_INTERVAL (REF_INTERVAL)
  ) u_sdram_sched_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .rdreq_i      (rdreq),
    .rdba_i       (rdba),
    .rdrow_i      (rdrow),
    .rdcol_i      (rdcol),
    .rdrdy_o      (rdrdy),
    .wrreq_i      (wrreq),
    .wrba_i       (wrba),
    .wrrow_i      (wrrow),
    .wrcol_i      (wrcol),
    .wrd_i        (wrd),
    .wrrdy_o      (wrrdy),
    .rdq_o        (rdq),
    .rdqvalid_o   (rdqvalid),
    .sdram_cmd_o  (bus_cmd),
    .sdram_ba_o   (bus_ba),
    .sdram_addr_o (bus_addr),
    .sdram_dq_i   (bus_dq_in),
    .sdram_dq_o   (bus_dq_out),
    .sdram_dqoe_o (bus_dqoe)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift_next();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_cmd(input string name, input sdram_sched_pkg::sdram_cmd_e got,
                           input sdram_sched_pkg::sdram_cmd_e exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_dq(input string name, input sdram_sched_pkg::dq_t got,
                          input sdram_sched_pkg::dq_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_ba(input string name, input sdram_sched_pkg::ba_t got,
                          input sdram_sched_pkg::ba_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input sdram_sched_pkg::addr_t got,
                            input sdram_sched_pkg::addr_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_idle_outputs();
    check_cmd("sdram_cmd_o", bus_cmd, sdram_sched_pkg::CMD_NOP);
    check_bit("sdram_dqoe_o", bus_dqoe, 1'b0);
    for (int p = 0; p < PORTS; p++)
    begin
      check_bit($sformatf("rdrdy_o[%0d]", p), rdrdy[p], 1'b0);
      check_bit($sformatf("wrrdy_o[%0d]", p), wrrdy[p], 1'b0);
      check_bit($sformatf("rdqvalid_o[%0d]", p), rdqvalid[p], 1'b0);
    end
  endtask

  // Shift the read pipeline and check what is due this cycle
  task automatic advance_read_bus();
    for (int k = 0; k < CL; k++)
    begin
      pipe_v[k]    = pipe_v[k+1];
      pipe_port[k] = pipe_port[k+1];
      pipe_data[k] = pipe_data[k+1];
    end
    pipe_v[CL] = 1'b0;
    for (int p = 0; p < PORTS; p++)
    begin
      check_bit($sformatf("rdqvalid_o[%0d]", p), rdqvalid[p], pipe_v[0] && pipe_port[0] == p);
      if (pipe_v[0])
        check_dq($sformatf("rdq_o[%0d]", p), rdq[p], pipe_data[0]);
    end
  endtask

  task automatic drive_read_data();
    bus_dq_in = pipe_v[1] ? pipe_data[1] : '0;
  endtask

  task automatic new_request(input int p);
    logic [31:0] r;
    r           = xorshift_next();
    pend[p]     = 1'b1;
    pend_rd[p]  = r[0];
    req_ba[p]   = r[2:1];
    req_row[p]  = sdram_sched_pkg::row_t'(r[4:3]);
    req_col[p]  = sdram_sched_pkg::col_t'(r[8:5]);
    req_data[p] = r[31:16];
    rdreq[p]    = r[0];
    wrreq[p]    = !r[0];
    // Idle side carries different fields
    rdba[p]     = r[0] ? req_ba[p] : ~req_ba[p];
    wrba[p]     = r[0] ? ~req_ba[p] : req_ba[p];
    rdrow[p]    = r[0] ? req_row[p] : ~req_row[p];
    wrrow[p]    = r[0] ? ~req_row[p] : req_row[p];
    rdcol[p]    = r[0] ? req_col[p] : ~req_col[p];
    wrcol[p]    = r[0] ? ~req_col[p] : req_col[p];
    wrd[p]      = req_data[p];
    issued      = issued + 1;
  endtask

  task automatic finish_request(input int p);
    logic [31:0] r;
    r         = xorshift_next();
    pend[p]   = 1'b0;
    rdreq[p]  = 1'b0;
    wrreq[p]  = 1'b0;
    gap[p]    = int'(r[1:0]);
    completed = completed + 1;
  endtask

  // Ready pulses must match the RD or WR on the bus
  task automatic check_ready_pulses(output int rd_port);
    int   n;
    logic wr_done;
    n       = 0;
    wr_done = 1'b0;
    rd_port = 0;
    for (int p = 0; p < PORTS; p++)
    begin
      if (rdrdy[p] === 1'b1 || wrrdy[p] === 1'b1)
      begin
        n = n + 1;
        check_bit($sformatf("rdrdy_o[%0d]", p), rdrdy[p], pend[p] && pend_rd[p]);
        check_bit($sformatf("wrrdy_o[%0d]", p), wrrdy[p], pend[p] && !pend_rd[p]);
        check_cmd("sdram_cmd_o", bus_cmd,
                  pend_rd[p] ? sdram_sched_pkg::CMD_RD : sdram_sched_pkg::CMD_WR);
        check_ba("sdram_ba_o", bus_ba, req_ba[p]);
        check_addr("sdram_addr_o", bus_addr, sdram_sched_pkg::addr_t'(req_col[p]));
        check_addr("open row", sdram_sched_pkg::addr_t'(open_row[req_ba[p]]),
                   sdram_sched_pkg::addr_t'(req_row[p]));
        if (!pend_rd[p])
        begin
          check_dq("sdram_dq_o", bus_dq_out, req_data[p]);
          wr_done = 1'b1;
        end
        rd_port = p;
        finish_request(p);
      end
      else
      begin
        check_bit($sformatf("rdrdy_o[%0d]", p), rdrdy[p], 1'b0);
        check_bit($sformatf("wrrdy_o[%0d]", p), wrrdy[p], 1'b0);
      end
    end
    check_bit("sdram_dqoe_o", bus_dqoe, wr_done);
    check_bit("ready pulse count", n == 1,
              bus_cmd == sdram_sched_pkg::CMD_RD || bus_cmd == sdram_sched_pkg::CMD_WR);
  endtask

  task automatic drive_requests();
    for (int p = 0; p < PORTS; p++)
      if (!pend[p] && issued < NUM_TXN)
      begin
        if (gap[p] == 0)
          new_request(p);
        else
          gap[p] = gap[p] - 1;
      end
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    int rd_port;
    rng_state = 32'd35665;
    rst_n     = 1'b0;
    bus_dq_in = '0;
    cyc       = 0;
    issued    = 0;
    completed = 0;
    drain     = 0;
    for (int p = 0; p < PORTS; p++)
    begin
      rdreq[p]   = 1'b0;
      wrreq[p]   = 1'b0;
      rdba[p]    = '0;
      wrba[p]    = '0;
      rdrow[p]   = '0;
      wrrow[p]   = '0;
      rdcol[p]   = '0;
      wrcol[p]   = '0;
      wrd[p]     = '0;
      pend[p]    = 1'b0;
      pend_rd[p] = 1'b0;
      gap[p]     = 0;
    end
    reset_model();

    repeat (4)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;

    while (completed < NUM_TXN || drain < CL + 2)
    begin
      @(negedge clk);
      cyc = cyc + 1;
      if (cyc > TIMEOUT)
        fail_run($sformatf("Timeout after %0d cycles, %0d of %0d requests done",
                           cyc, completed, NUM_TXN));
      // First cycle out of reset is still idle
      if (cyc == 1)
        check_idle_outputs();
      advance_read_bus();
      check_ready_pulses(rd_port);
      track_command(rd_port);
      drive_read_data();
      drive_requests();
      if (completed >= NUM_TXN)
        drain = drain + 1;
    end

    if (ref_count >= cyc / REF_INTERVAL - 2)
    begin
      $display("TEST OK");
      $finish;
    end
    else
      fail_run($sformatf("Only %0d REF commands were issued in %0d cycles", ref_count, cyc));
  end

endmodule

`default_nettype wire

// File: sdram_sched.f
+incdir+verification
design/sdram_sched_pkg.sv
design/sdram_cmd_if.sv
design/sdram_bank_timer.sv
design/sdram_port_engine.sv
design/sdram_refresh_engine.sv
design/sdram_cmd_arbiter.sv
design/sdram_read_tracker.sv
design/sdram_sched_top.sv
verification/sdram_sched_tb.sv
